// File: Bender.yml
package:
  name: aes_encrypt_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/aesStatePkg.sv
      - common/aesFieldPkg.sv
      - logic/subBytes.sv
      - logic/keyScheduler.sv
      - cipherRound/roundTransform.sv
      - cipherRound/roundSequencer.sv
      - logic/aesEncryptCore.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/aesEncryptTb.sv

// File: cipherRound/roundSequencer.sv
// round control and ciphertext register

`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module roundSequencer import aesStatePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  start,
    input  stateT plaintext,
    input  keyT   cipherKey,
    input  stateT roundOut,
    output stateT curState,
    output logic  finalRound,
    output logic  loadKey,
    output logic  nextKey,
    output logic  busy,
    output logic  done,
    output stateT ciphertext
);

    localparam roundIdxT LastRound = roundIdxT'(`AES_NUM_ROUNDS);

    // round now executing, 0 while idle
    roundIdxT roundCnt;
    logic     accept;

    // a start during a block is dropped
    assign accept = start && !busy;

    assign finalRound = (roundCnt == LastRound);

    // key scheduler follows the same accept and step pulses
    assign loadKey = accept;
    assign nextKey = busy;

    // state register
    // whitening on accept, then one round result per edge
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            curState <= plaintext ^ cipherKey;
        end
        else if (busy)
        begin
            curState <= roundOut;
        end
    end

    // control and held result
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            roundCnt   <= '0;
            ciphertext <= '0;
        end
        else
        begin
            // done is a one-cycle pulse
            done <= 1'b0;
            if (accept)
            begin
                busy     <= 1'b1;
                roundCnt <= roundIdxT'(1);
            end
            else if (busy)
            begin
                if (finalRound)
                begin
                    // round 10 output is the ciphertext, held until the next block
                    ciphertext <= roundOut;
                    done       <= 1'b1;
                    busy       <= 1'b0;
                    roundCnt   <= '0;
                end
                else
                begin
                    roundCnt <= roundCnt + roundIdxT'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cipherRound/roundTransform.sv
// one AES encryption round

`timescale 1ns/1ns
`default_nettype none

module roundTransform import aesStatePkg::*, aesFieldPkg::*; (
    input  stateT curState,
    input  keyT   roundKey,
    input  logic  finalRound,
    output stateT roundOut
);

    localparam int NumCols  = $bits(stateT) / $bits(wordT);
    localparam int NumRows  = $bits(wordT) / $bits(byteT);
    localparam int ByteBits = $bits(byteT);
    localparam int TopBit   = $bits(stateT) - 1;

    stateT subOut;
    stateT shifted;
    stateT mixed;

    subBytes #(
        .payloadT(stateT)
    ) u_subBytes (
        .in (curState),
        .out(subOut)
    );

    // ShiftRows, row r of column c comes from column c+r
    // byte index is NumRows*col + row, byte 0 in the top bits
    always_comb
    begin
        for (int c = 0; c < NumCols; c++)
        begin
            for (int r = 0; r < NumRows; r++)
            begin
                shifted[TopBit-ByteBits*(NumRows*c+r) -: ByteBits] =
                    subOut[TopBit-ByteBits*(NumRows*((c+r)%NumCols)+r) -: ByteBits];
            end
        end
    end

    // MixColumns per column, left out in round 10
    always_comb
    begin
        for (int c = 0; c < NumCols; c++)
        begin
            mixed[TopBit-$bits(wordT)*c -: $bits(wordT)] = finalRound ?
                shifted[TopBit-$bits(wordT)*c -: $bits(wordT)] :
                mixColumn(shifted[TopBit-$bits(wordT)*c -: $bits(wordT)]);
        end
    end

    // AddRoundKey
    assign roundOut = mixed ^ roundKey;

endmodule

`default_nettype wire

// File: common/aesFieldPkg.sv
// GF(2^8) arithmetic

`default_nettype none

package aesFieldPkg;

    import aesStatePkg::*;

    // bits per field element
    localparam int GfBits = 8;

    // low byte of the reduction polynomial x^8 + x^4 + x^3 + x + 1
    localparam byteT GfPoly = 8'h1b;

    // multiply by x, fold the carry back with the polynomial
    function automatic byteT xtime(input byteT b);
        return {b[GfBits-2:0], 1'b0} ^ (b[GfBits-1] ? GfPoly : byteT'(0));
    endfunction

    // one MixColumns column
    // matrix rows are {2 3 1 1} rotated right once per output byte
    function automatic wordT mixColumn(input wordT col);
        byteT a0;
        byteT a1;
        byteT a2;
        byteT a3;
        wordT res;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // times 3 is xtime plus the byte itself
        res[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        res[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        res[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        res[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        return res;
    endfunction

endpackage

`default_nettype wire

// File: common/aesStatePkg.sv
// AES data shape types

`default_nettype none

package aesStatePkg;

`include "aes_settings.svh"

    // one byte of the state, also one GF(2^8) element
    typedef logic [7:0] byteT;

    // one column of the state or one key word
    typedef logic [`AES_BLOCK_BITS/`AES_NUM_COLS-1:0] wordT;

    // full state, byte 0 in the top bits, columns filled first
    typedef logic [`AES_BLOCK_BITS-1:0] stateT;

    // cipher key or round key
    typedef logic [`AES_BLOCK_BITS-1:0] keyT;

    // round number, 0 while idle and 1 to 10 while running
    typedef logic [$clog2(`AES_NUM_ROUNDS+1)-1:0] roundIdxT;

endpackage

`default_nettype wire

// File: common/aes_settings.svh
// AES-128 core constants

`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// width of one cipher block, also the key width in this cut
`define AES_BLOCK_BITS 128

// round count for a 128-bit key
`define AES_NUM_ROUNDS 10

// number of 32-bit columns in the state
`define AES_NUM_COLS 4

// Nb stays 4 for every AES variant
// Nr would grow with the key size, fixed here

`endif

// File: dv/aesEncryptTb.sv
// AES-128 core testbench

`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aesEncryptTb import aesStatePkg::*; ();

    localparam int    ClkHalf     = 4;
    localparam int    DoneTimeout = 4 * `AES_NUM_ROUNDS;
    localparam int    IdleCycles  = 6;
    localparam int    MaxLines    = 64;
    localparam string VectorFile  = "dv/aes_vectors.txt";

    logic  clk;
    logic  rstN;
    logic  start;
    stateT plaintext;
    keyT   cipherKey;
    logic  busy;
    logic  done;
    stateT ciphertext;

    // known-answer triples from the vector file
    keyT   vecKey[$];
    stateT vecPlain[$];
    stateT vecCipher[$];

    logic [15:0] lfsrState;
    int          errorCount;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    logic        timedOut;

    aesEncryptCore u_aesEncryptCore (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .plaintext (plaintext),
        .cipherKey (cipherKey),
        .busy      (busy),
        .done      (done),
        .ciphertext(ciphertext)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #ClkHalf clk = ~clk;
        end
    end

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic randomBlock(output logic [`AES_BLOCK_BITS-1:0] val);
        for (int i = 0; i < `AES_BLOCK_BITS; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            val = {val[`AES_BLOCK_BITS-2:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(
        input string                     name,
        input logic [`AES_BLOCK_BITS-1:0] actual,
        input logic [`AES_BLOCK_BITS-1:0] expected
    );
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    // one result line per test
    task automatic endTest(input string name);
        testsRun++;
        if (testErrors == 0)
        begin
            $display("PASS  %s", name);
        end
        else
        begin
            testsFailed++;
            $display("FAIL  %s (%0d errors)", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: no %s within %0d clock cycles", what, DoneTimeout);
        timedOut = 1'b1;
        errorCount++;
        testErrors++;
    endtask

    task automatic loadVectors();
        int    fd;
        int    lineCount;
        int    fields;
        int    status;
        string line;
        keyT   k;
        stateT p;
        stateT c;
        fd = $fopen(VectorFile, "r");
        if (fd == 0)
        begin
            $display("cannot open vector file %s", VectorFile);
            errorCount++;
            return;
        end
        lineCount = 0;
        while (!$feof(fd) && lineCount < MaxLines)
        begin
            lineCount++;
            line = "";
            status = $fgets(line, fd);
            // header and blank lines carry no vector
            if (status > 0 && line.len() > 0 && line[0] != "#")
            begin
                fields = $sscanf(line, "%h %h %h", k, p, c);
                if (fields == 3)
                begin
                    vecKey.push_back(k);
                    vecPlain.push_back(p);
                    vecCipher.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // start high for one edge
    // returns right after the accepting edge
    task automatic launchBlock(input keyT key, input stateT pt);
        @(posedge clk);
        start     <= 1'b1;
        cipherKey <= key;
        plaintext <= pt;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // counts edges from the accepting edge until done shows up
    task automatic waitForDone(
        input  string what,
        input  logic  armNext,
        input  keyT   nextCipherKey,
        input  stateT nextPlain,
        output int    edges,
        output int    busyLow
    );
        edges   = 1;
        busyLow = 0;
        @(negedge clk);
        while (!done && !timedOut)
        begin
            if (!busy)
            begin
                busyLow++;
            end
            if (edges >= DoneTimeout)
            begin
                reportTimeout(what);
            end
            else
            begin
                @(posedge clk);
                edges++;
                // next start lands in the done cycle
                if (armNext && edges == `AES_NUM_ROUNDS + 1)
                begin
                    start     <= 1'b1;
                    cipherKey <= nextCipherKey;
                    plaintext <= nextPlain;
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic resetStateTest();
        @(negedge clk);
        checkValue("busy", busy, 1'b0);
        checkValue("done", done, 1'b0);
        checkValue("ciphertext", ciphertext, '0);
        endTest("reset state");
    endtask

    task automatic knownAnswerTest();
        int edges;
        int busyLow;
        if (timedOut)
            return;
        for (int v = 0; v < vecKey.size(); v++)
        begin
            launchBlock(vecKey[v], vecPlain[v]);
            waitForDone("done", 1'b0, '0, '0, edges, busyLow);
            checkValue($sformatf("ciphertext[%0d]", v), ciphertext, vecCipher[v]);
        end
        endTest("known-answer encryption");
    endtask

    task automatic latencyTest();
        int edges;
        int busyLow;
        if (timedOut)
            return;
        launchBlock(vecKey[1], vecPlain[1]);
        waitForDone("done", 1'b0, '0, '0, edges, busyLow);
        checkValue("done latency", edges, `AES_NUM_ROUNDS + 1);
        checkValue("busy low while running", busyLow, 0);
        checkValue("busy", busy, 1'b0);
        checkValue("ciphertext", ciphertext, vecCipher[1]);
        // pulse is one cycle wide
        @(posedge clk);
        @(negedge clk);
        checkValue("done", done, 1'b0);
        endTest("fixed latency");
    endtask

    task automatic ignoredStartTest();
        stateT junkPlain;
        keyT   junkKey;
        int    edges;
        int    busyLow;
        int    pulses;
        if (timedOut)
            return;
        randomBlock(junkPlain);
        randomBlock(junkKey);
        launchBlock(vecKey[0], vecPlain[0]);
        repeat (3) @(posedge clk);
        // stray start a few rounds in
        start     <= 1'b1;
        plaintext <= junkPlain;
        cipherKey <= junkKey;
        @(negedge clk);
        checkValue("busy at stray start", busy, 1'b1);
        // result of the previous block stays on the output while this one runs
        checkValue("held ciphertext while busy", ciphertext, vecCipher[1]);
        @(posedge clk);
        start <= 1'b0;
        waitForDone("done", 1'b0, '0, '0, edges, busyLow);
        checkValue("ciphertext", ciphertext, vecCipher[0]);
        pulses = done ? 1 : 0;
        repeat (2 * `AES_NUM_ROUNDS)
        begin
            @(posedge clk);
            @(negedge clk);
            if (done)
            begin
                pulses++;
            end
        end
        checkValue("done pulses", pulses, 1);
        endTest("start ignored while busy");
    endtask

    task automatic heldOutputTest();
        int last;
        int edges;
        int busyLow;
        if (timedOut)
            return;
        last = vecKey.size() - 1;
        launchBlock(vecKey[last], vecPlain[last]);
        waitForDone("done", 1'b0, '0, '0, edges, busyLow);
        repeat (IdleCycles)
        begin
            @(posedge clk);
            @(negedge clk);
            checkValue("held ciphertext", ciphertext, vecCipher[last]);
        end
        // second block is started while done of the first is high
        launchBlock(vecKey[0], vecPlain[0]);
        waitForDone("first done", 1'b1, vecKey[1], vecPlain[1], edges, busyLow);
        checkValue("first ciphertext", ciphertext, vecCipher[0]);
        @(posedge clk);
        start <= 1'b0;
        waitForDone("second done", 1'b0, '0, '0, edges, busyLow);
        checkValue("back-to-back latency", edges, `AES_NUM_ROUNDS + 1);
        checkValue("second ciphertext", ciphertext, vecCipher[1]);
        endTest("held output and back-to-back start");
    endtask

    task automatic midResetTest();
        int edges;
        int busyLow;
        int pulses;
        if (timedOut)
            return;
        launchBlock(vecKey[0], vecPlain[0]);
        repeat (4) @(posedge clk);
        rstN <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("busy after reset", busy, 1'b0);
        checkValue("done after reset", done, 1'b0);
        checkValue("ciphertext after reset", ciphertext, '0);
        pulses = 0;
        repeat (2 * `AES_NUM_ROUNDS)
        begin
            @(posedge clk);
            @(negedge clk);
            if (done || busy)
            begin
                pulses++;
            end
        end
        checkValue("activity after reset", pulses, 0);
        // core must still work afterwards
        launchBlock(vecKey[0], vecPlain[0]);
        waitForDone("done after reset", 1'b0, '0, '0, edges, busyLow);
        checkValue("ciphertext", ciphertext, vecCipher[0]);
        endTest("reset mid-operation");
    endtask

    initial
    begin
        lfsrState   = 16'd62;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        timedOut    = 1'b0;
        rstN      <= 1'b0;
        start     <= 1'b0;
        plaintext <= '0;
        cipherKey <= '0;
        loadVectors();
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        resetStateTest();
        if (vecKey.size() >= 2)
        begin
            knownAnswerTest();
            latencyTest();
            ignoredStartTest();
            heldOutputTest();
            midResetTest();
        end
        else
        begin
            $display("vector file holds fewer than two usable vectors");
            errorCount++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0 && !timedOut)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/aes_vectors.txt
# cipher key   plaintext   expected ciphertext
# 32 hex digits per column with byte 0 leftmost
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e

// File: logic/aesEncryptCore.sv
// AES-128 encryption core top

`timescale 1ns/1ns
`default_nettype none

module aesEncryptCore import aesStatePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  start,
    input  stateT plaintext,
    input  keyT   cipherKey,
    output logic  busy,
    output logic  done,
    output stateT ciphertext
);

    // sequencer to round datapath
    stateT curState;
    stateT roundOut;
    logic  finalRound;

    // sequencer to key scheduler
    logic  loadKey;
    logic  nextKey;
    keyT   roundKey;

    // whitening, round count and output holding
    roundSequencer u_roundSequencer (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .plaintext (plaintext),
        .cipherKey (cipherKey),
        .roundOut  (roundOut),
        .curState  (curState),
        .finalRound(finalRound),
        .loadKey   (loadKey),
        .nextKey   (nextKey),
        .busy      (busy),
        .done      (done),
        .ciphertext(ciphertext)
    );

    // shared round logic, one round per clock
    roundTransform u_roundTransform (
        .curState  (curState),
        .roundKey  (roundKey),
        .finalRound(finalRound),
        .roundOut  (roundOut)
    );

    // round keys derived one step at a time
    keyScheduler u_keyScheduler (
        .clk      (clk),
        .rstN     (rstN),
        .loadKey  (loadKey),
        .nextKey  (nextKey),
        .cipherKey(cipherKey),
        .roundKey (roundKey)
    );

endmodule

`default_nettype wire

// File: logic/keyScheduler.sv
// on-the-fly round key generator

`timescale 1ns/1ns
`default_nettype none

module keyScheduler import aesStatePkg::*, aesFieldPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic loadKey,
    input  logic nextKey,
    input  keyT  cipherKey,
    output keyT  roundKey
);

    localparam int NumWords = $bits(keyT) / $bits(wordT);

    // key of the previous round and the rcon byte for the next step
    keyT  keyReg;
    byteT rcon;

    wordT rotWord;
    wordT subWord;
    wordT headWord;

    // RotWord on the last word, byte 1 moves to the top
    assign rotWord = {keyReg[23:0], keyReg[31:24]};

    // SubWord shares the byte table with the round datapath
    subBytes #(
        .payloadT(wordT)
    ) u_subWord (
        .in (rotWord),
        .out(subWord)
    );

    // round constant sits in the top byte of the word
    assign headWord = subWord ^ {rcon, 24'h000000};

    // successor key, each word folds in the one before it
    // this is the key of the round now executing
    always_comb
    begin
        wordT carry;
        carry = headWord;
        for (int w = 0; w < NumWords; w++)
        begin
            carry = carry ^ keyReg[$bits(keyT)-1-w*$bits(wordT) -: $bits(wordT)];
            roundKey[$bits(keyT)-1-w*$bits(wordT) -: $bits(wordT)] = carry;
        end
    end

    // load takes the cipher key, each round step advances by one
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            keyReg <= '0;
            rcon   <= '0;
        end
        else if (loadKey)
        begin
            keyReg <= cipherKey;
            rcon   <= 8'h01;
        end
        else if (nextKey)
        begin
            keyReg <= roundKey;
            // 01 02 04 .. 80 1b 36
            rcon   <= xtime(rcon);
        end
    end

endmodule

`default_nettype wire

// File: logic/subBytes.sv
// S-box substitution

`timescale 1ns/1ns
`default_nettype none

module subBytes import aesStatePkg::*, aesFieldPkg::*; #(
    parameter type payloadT = wordT
) (
    input  payloadT in,
    output payloadT out
);

    // byte count follows the payload width
    localparam int NumBytes = $bits(payloadT) / GfBits;

    // forward S-box, row = high nibble, four entries per line
    function automatic byteT sbox(input byteT b);
        byteT s;
        case (b)
            8'h00: s = 8'h63; 8'h01: s = 8'h7c; 8'h02: s = 8'h77; 8'h03: s = 8'h7b;
            8'h04: s = 8'hf2; 8'h05: s = 8'h6b; 8'h06: s = 8'h6f; 8'h07: s = 8'hc5;
            8'h08: s = 8'h30; 8'h09: s = 8'h01; 8'h0a: s = 8'h67; 8'h0b: s = 8'h2b;
            8'h0c: s = 8'hfe; 8'h0d: s = 8'hd7; 8'h0e: s = 8'hab; 8'h0f: s = 8'h76;
            8'h10: s = 8'hca; 8'h11: s = 8'h82; 8'h12: s = 8'hc9; 8'h13: s = 8'h7d;
            8'h14: s = 8'hfa; 8'h15: s = 8'h59; 8'h16: s = 8'h47; 8'h17: s = 8'hf0;
            8'h18: s = 8'had; 8'h19: s = 8'hd4; 8'h1a: s = 8'ha2; 8'h1b: s = 8'haf;
            8'h1c: s = 8'h9c; 8'h1d: s = 8'ha4; 8'h1e: s = 8'h72; 8'h1f: s = 8'hc0;
            8'h20: s = 8'hb7; 8'h21: s = 8'hfd; 8'h22: s = 8'h93; 8'h23: s = 8'h26;
            8'h24: s = 8'h36; 8'h25: s = 8'h3f; 8'h26: s = 8'hf7; 8'h27: s = 8'hcc;
            8'h28: s = 8'h34; 8'h29: s = 8'ha5; 8'h2a: s = 8'he5; 8'h2b: s = 8'hf1;
            8'h2c: s = 8'h71; 8'h2d: s = 8'hd8; 8'h2e: s = 8'h31; 8'h2f: s = 8'h15;
            8'h30: s = 8'h04; 8'h31: s = 8'hc7; 8'h32: s = 8'h23; 8'h33: s = 8'hc3;
            8'h34: s = 8'h18; 8'h35: s = 8'h96; 8'h36: s = 8'h05; 8'h37: s = 8'h9a;
            8'h38: s = 8'h07; 8'h39: s = 8'h12; 8'h3a: s = 8'h80; 8'h3b: s = 8'he2;
            8'h3c: s = 8'heb; 8'h3d: s = 8'h27; 8'h3e: s = 8'hb2; 8'h3f: s = 8'h75;
            8'h40: s = 8'h09; 8'h41: s = 8'h83; 8'h42: s = 8'h2c; 8'h43: s = 8'h1a;
            8'h44: s = 8'h1b; 8'h45: s = 8'h6e; 8'h46: s = 8'h5a; 8'h47: s = 8'ha0;
            8'h48: s = 8'h52; 8'h49: s = 8'h3b; 8'h4a: s = 8'hd6; 8'h4b: s = 8'hb3;
            8'h4c: s = 8'h29; 8'h4d: s = 8'he3; 8'h4e: s = 8'h2f; 8'h4f: s = 8'h84;
            8'h50: s = 8'h53; 8'h51: s = 8'hd1; 8'h52: s = 8'h00; 8'h53: s = 8'hed;
            8'h54: s = 8'h20; 8'h55: s = 8'hfc; 8'h56: s = 8'hb1; 8'h57: s = 8'h5b;
            8'h58: s = 8'h6a; 8'h59: s = 8'hcb; 8'h5a: s = 8'hbe; 8'h5b: s = 8'h39;
            8'h5c: s = 8'h4a; 8'h5d: s = 8'h4c; 8'h5e: s = 8'h58; 8'h5f: s = 8'hcf;
            8'h60: s = 8'hd0; 8'h61: s = 8'hef; 8'h62: s = 8'haa; 8'h63: s = 8'hfb;
            8'h64: s = 8'h43; 8'h65: s = 8'h4d; 8'h66: s = 8'h33; 8'h67: s = 8'h85;
            8'h68: s = 8'h45; 8'h69: s = 8'hf9; 8'h6a: s = 8'h02; 8'h6b: s = 8'h7f;
            8'h6c: s = 8'h50; 8'h6d: s = 8'h3c; 8'h6e: s = 8'h9f; 8'h6f: s = 8'ha8;
            8'h70: s = 8'h51; 8'h71: s = 8'ha3; 8'h72: s = 8'h40; 8'h73: s = 8'h8f;
            8'h74: s = 8'h92; 8'h75: s = 8'h9d; 8'h76: s = 8'h38; 8'h77: s = 8'hf5;
            8'h78: s = 8'hbc; 8'h79: s = 8'hb6; 8'h7a: s = 8'hda; 8'h7b: s = 8'h21;
            8'h7c: s = 8'h10; 8'h7d: s = 8'hff; 8'h7e: s = 8'hf3; 8'h7f: s = 8'hd2;
            8'h80: s = 8'hcd; 8'h81: s = 8'h0c; 8'h82: s = 8'h13; 8'h83: s = 8'hec;
            8'h84: s = 8'h5f; 8'h85: s = 8'h97; 8'h86: s = 8'h44; 8'h87: s = 8'h17;
            8'h88: s = 8'hc4; 8'h89: s = 8'ha7; 8'h8a: s = 8'h7e; 8'h8b: s = 8'h3d;
            8'h8c: s = 8'h64; 8'h8d: s = 8'h5d; 8'h8e: s = 8'h19; 8'h8f: s = 8'h73;
            8'h90: s = 8'h60; 8'h91: s = 8'h81; 8'h92: s = 8'h4f; 8'h93: s = 8'hdc;
            8'h94: s = 8'h22; 8'h95: s = 8'h2a; 8'h96: s = 8'h90; 8'h97: s = 8'h88;
            8'h98: s = 8'h46; 8'h99: s = 8'hee; 8'h9a: s = 8'hb8; 8'h9b: s = 8'h14;
            8'h9c: s = 8'hde; 8'h9d: s = 8'h5e; 8'h9e: s = 8'h0b; 8'h9f: s = 8'hdb;
            8'ha0: s = 8'he0; 8'ha1: s = 8'h32; 8'ha2: s = 8'h3a; 8'ha3: s = 8'h0a;
            8'ha4: s = 8'h49; 8'ha5: s = 8'h06; 8'ha6: s = 8'h24; 8'ha7: s = 8'h5c;
            8'ha8: s = 8'hc2; 8'ha9: s = 8'hd3; 8'haa: s = 8'hac; 8'hab: s = 8'h62;
            8'hac: s = 8'h91; 8'had: s = 8'h95; 8'hae: s = 8'he4; 8'haf: s = 8'h79;
            8'hb0: s = 8'he7; 8'hb1: s = 8'hc8; 8'hb2: s = 8'h37; 8'hb3: s = 8'h6d;
            8'hb4: s = 8'h8d; 8'hb5: s = 8'hd5; 8'hb6: s = 8'h4e; 8'hb7: s = 8'ha9;
            8'hb8: s = 8'h6c; 8'hb9: s = 8'h56; 8'hba: s = 8'hf4; 8'hbb: s = 8'hea;
            8'hbc: s = 8'h65; 8'hbd: s = 8'h7a; 8'hbe: s = 8'hae; 8'hbf: s = 8'h08;
            8'hc0: s = 8'hba; 8'hc1: s = 8'h78; 8'hc2: s = 8'h25; 8'hc3: s = 8'h2e;
            8'hc4: s = 8'h1c; 8'hc5: s = 8'ha6; 8'hc6: s = 8'hb4; 8'hc7: s = 8'hc6;
            8'hc8: s = 8'he8; 8'hc9: s = 8'hdd; 8'hca: s = 8'h74; 8'hcb: s = 8'h1f;
            8'hcc: s = 8'h4b; 8'hcd: s = 8'hbd; 8'hce: s = 8'h8b; 8'hcf: s = 8'h8a;
            8'hd0: s = 8'h70; 8'hd1: s = 8'h3e; 8'hd2: s = 8'hb5; 8'hd3: s = 8'h66;
            8'hd4: s = 8'h48; 8'hd5: s = 8'h03; 8'hd6: s = 8'hf6; 8'hd7: s = 8'h0e;
            8'hd8: s = 8'h61; 8'hd9: s = 8'h35; 8'hda: s = 8'h57; 8'hdb: s = 8'hb9;
            8'hdc: s = 8'h86; 8'hdd: s = 8'hc1; 8'hde: s = 8'h1d; 8'hdf: s = 8'h9e;
            8'he0: s = 8'he1; 8'he1: s = 8'hf8; 8'he2: s = 8'h98; 8'he3: s = 8'h11;
            8'he4: s = 8'h69; 8'he5: s = 8'hd9; 8'he6: s = 8'h8e; 8'he7: s = 8'h94;
            8'he8: s = 8'h9b; 8'he9: s = 8'h1e; 8'hea: s = 8'h87; 8'heb: s = 8'he9;
            8'hec: s = 8'hce; 8'hed: s = 8'h55; 8'hee: s = 8'h28; 8'hef: s = 8'hdf;
            8'hf0: s = 8'h8c; 8'hf1: s = 8'ha1; 8'hf2: s = 8'h89; 8'hf3: s = 8'h0d;
            8'hf4: s = 8'hbf; 8'hf5: s = 8'he6; 8'hf6: s = 8'h42; 8'hf7: s = 8'h68;
            8'hf8: s = 8'h41; 8'hf9: s = 8'h99; 8'hfa: s = 8'h2d; 8'hfb: s = 8'h0f;
            8'hfc: s = 8'hb0; 8'hfd: s = 8'h54; 8'hfe: s = 8'hbb; 8'hff: s = 8'h16;
        endcase
        return s;
    endfunction

    // every byte goes through its own copy of the table
    always_comb
    begin
        for (int i = 0; i < NumBytes; i++)
        begin
            out[i*GfBits +: GfBits] = sbox(in[i*GfBits +: GfBits]);
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/aesStatePkg.sv
common/aesFieldPkg.sv
logic/subBytes.sv
logic/keyScheduler.sv
cipherRound/roundTransform.sv
cipherRound/roundSequencer.sv
logic/aesEncryptCore.sv
dv/aesEncryptTb.sv
